//--- project.f
source/sfpp_io_pkg.sv
source/status_sync.sv
source/sfpp_reg_ctrl.sv
source/mdio_master.sv
source/sfpp_io_core.sv
tb/mdio_phy_model.sv
tb/sfpp_io_tb.sv

//--- source/mdio_master.sv
`timescale 1ns/1ns
// Clause-22 MDIO master on the register port
// One command write runs one 64-period management frame, MDC divided down
module mdio_master
   import sfpp_io_pkg::*;
(
   input  logic      bus_clk,
   input  logic      bus_rst,
   // Register port
   input  logic      reg_wr_req_i,
   input  reg_addr_t reg_wr_addr_i,
   input  reg_data_t reg_wr_data_i,
   input  logic      reg_rd_req_i,
   input  reg_addr_t reg_rd_addr_i,
   output logic      reg_rd_resp_o,
   output reg_data_t reg_rd_data_o,
   // MDIO pins
   output logic      mdc_o,
   output logic      mdio_o,
   output logic      mdio_oe_o,
   input  logic      mdio_i
);

   mdio_state_t          state;
   logic                 busy;
   logic                 cmd_rnw;     // Frame in flight is a read
   logic [31:0]          frame_sr;    // Start..data, MSB goes out first
   logic [4:0]           bit_cnt;     // Bit within current field
   logic                 bit_last;
   logic [MDC_CNT_W-1:0] div_cnt;
   logic                 mdc_q;
   logic                 half_tick;
   logic                 mdc_rise;
   logic                 mdc_fall;
   mdio_data_t           rd_data_q;
   // Command fields
   mdio_data_t           cmd_wdata;
   mdio_addr_t           cmd_reg;
   mdio_addr_t           cmd_phy;
   logic                 cmd_start;

   assign cmd_wdata = reg_wr_data_i[15:0];
   assign cmd_reg   = reg_wr_data_i[20:16];
   assign cmd_phy   = reg_wr_data_i[25:21];
   // Commands while busy are dropped
   assign cmd_start = reg_wr_req_i && (reg_wr_addr_i == REG_MDIO_CMD) && !busy;

   // ------------------------------
   // MDC divider
   // ------------------------------
   assign half_tick = (div_cnt == MDC_CNT_W'(MDC_HALF_PERIOD - 1));
   assign mdc_rise  = half_tick && !mdc_q;
   assign mdc_fall  = half_tick && mdc_q;   // Ends a bit period

   always_ff @(posedge bus_clk) begin
      if (bus_rst || state == IDLE) begin   // MDC parked low when idle
         div_cnt <= '0;
         mdc_q   <= 1'b0;
      end else if (half_tick) begin
         div_cnt <= '0;
         mdc_q   <= ~mdc_q;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign mdc_o = mdc_q;

   // ------------------------------
   // Frame FSM
   // ------------------------------
   always_comb begin
      case (state)
         PREAMBLE:   bit_last = (bit_cnt == 5'(MDIO_PREAMBLE_BITS - 1));
         HEADER:     bit_last = (bit_cnt == 5'(MDIO_HEADER_BITS - 1));
         TURNAROUND: bit_last = (bit_cnt == 5'(MDIO_TA_BITS - 1));
         DATA:       bit_last = (bit_cnt == 5'(MDIO_DATA_BITS - 1));
         default:    bit_last = 1'b0;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         state     <= IDLE;
         busy      <= 1'b0;
         mdio_oe_o <= 1'b0;
         bit_cnt   <= '0;
      end else begin
         if (state == IDLE || (mdc_fall && bit_last))
            bit_cnt <= '0;
         else if (mdc_fall)
            bit_cnt <= bit_cnt + 1'b1;

         case (state)
            IDLE: begin
               if (cmd_start) begin
                  state     <= PREAMBLE;
                  busy      <= 1'b1;
                  mdio_oe_o <= 1'b1;       // Drive preamble ones
               end
            end
            PREAMBLE: begin
               if (mdc_fall && bit_last)
                  state <= HEADER;
            end
            HEADER: begin
               if (mdc_fall && bit_last) begin
                  state <= TURNAROUND;
                  if (cmd_rnw)
                     mdio_oe_o <= 1'b0;    // PHY owns the line from TA on
               end
            end
            TURNAROUND: begin
               if (mdc_fall && bit_last)
                  state <= DATA;
            end
            DATA: begin
               if (mdc_fall && bit_last) begin
                  state     <= FINISH;
                  mdio_oe_o <= 1'b0;
               end
            end
            FINISH: begin
               state <= IDLE;
               busy  <= 1'b0;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // ------------------------------
   // Shift paths
   // ------------------------------
   always_ff @(posedge bus_clk) begin
      if (cmd_start) begin
         cmd_rnw  <= reg_wr_data_i[26];
         frame_sr <= {2'b01,                                    // Start
                      reg_wr_data_i[26] ? 2'b10 : 2'b01,        // Opcode
                      cmd_phy, cmd_reg,
                      reg_wr_data_i[26] ? 2'b11 : 2'b10,        // TA
                      cmd_wdata};
      end else if (mdc_fall && state != PREAMBLE) begin
         frame_sr <= {frame_sr[30:0], 1'b0};  // Next bit after MDC falls
      end
   end

   assign mdio_o = (state == IDLE || state == PREAMBLE) ? 1'b1 : frame_sr[31];

   always_ff @(posedge bus_clk) begin
      if (bus_rst)
         rd_data_q <= '0;
      else if (mdc_rise && state == DATA && cmd_rnw)
         rd_data_q <= {rd_data_q[14:0], mdio_i};  // Sampled as MDC rises
   end

   // Status register read, one cycle latency
   always_ff @(posedge bus_clk) begin
      if (bus_rst)
         reg_rd_resp_o <= 1'b0;
      else
         reg_rd_resp_o <= reg_rd_req_i && (reg_rd_addr_i == REG_MDIO_STATUS);
   end

   always_ff @(posedge bus_clk) begin
      if (reg_rd_req_i)
         reg_rd_data_o <= {15'h0000, busy, rd_data_q};
   end

   // Read frames never fight the PHY during data bits
   assert property (@(posedge bus_clk) disable iff (bus_rst)
      (state == DATA && cmd_rnw) |-> !mdio_oe_o);

   // Idle means MDC parked low and the line released
   assert property (@(posedge bus_clk) disable iff (bus_rst)
      !busy |-> (state == IDLE && !mdc_o && !mdio_oe_o));

endmodule

//--- source/sfpp_io_core.sv
`timescale 1ns/1ns
// SFP+ port management core
// Register port reaching control words, synced status and the MDIO master
module sfpp_io_core
   import sfpp_io_pkg::*;
(
   input  logic        bus_clk,
   input  logic        bus_rst,
   // Register port
   input  logic        reg_wr_req_i,
   input  reg_addr_t   reg_wr_addr_i,
   input  reg_data_t   reg_wr_data_i,
   input  logic        reg_rd_req_i,
   input  reg_addr_t   reg_rd_addr_i,
   output logic        reg_rd_resp_o,
   output reg_data_t   reg_rd_data_o,
   // Status in, asynchronous
   input  mac_status_t mac_status_i,
   input  phy_status_t phy_status_i,
   // Control out
   output logic        tx_enable_o,
   output logic        phy_reset_o,
   output logic        sfpp_tx_disable_o,
   // MDIO pins
   output logic        mdc_o,
   output logic        mdio_o,
   output logic        mdio_oe_o,
   input  logic        mdio_i
);

   mac_status_t mac_status_sync;
   phy_status_t phy_status_sync;
   logic        mdio_rd_resp;     // MDIO status read response
   reg_data_t   mdio_rd_data;

   status_sync status_sync0 (
      .bus_clk      (bus_clk),
      .bus_rst      (bus_rst),
      .mac_status_i (mac_status_i),
      .phy_status_i (phy_status_i),
      .mac_status_o (mac_status_sync),
      .phy_status_o (phy_status_sync)
   );

   sfpp_reg_ctrl reg_ctrl0 (
      .bus_clk           (bus_clk),
      .bus_rst           (bus_rst),
      .reg_wr_req_i      (reg_wr_req_i),
      .reg_wr_addr_i     (reg_wr_addr_i),
      .reg_wr_data_i     (reg_wr_data_i),
      .reg_rd_req_i      (reg_rd_req_i),
      .reg_rd_addr_i     (reg_rd_addr_i),
      .mac_status_i      (mac_status_sync),
      .phy_status_i      (phy_status_sync),
      .mdio_rd_resp_i    (mdio_rd_resp),
      .mdio_rd_data_i    (mdio_rd_data),
      .reg_rd_resp_o     (reg_rd_resp_o),
      .reg_rd_data_o     (reg_rd_data_o),
      .tx_enable_o       (tx_enable_o),
      .phy_reset_o       (phy_reset_o),
      .sfpp_tx_disable_o (sfpp_tx_disable_o)
   );

   mdio_master mdio_master0 (
      .bus_clk       (bus_clk),
      .bus_rst       (bus_rst),
      .reg_wr_req_i  (reg_wr_req_i),
      .reg_wr_addr_i (reg_wr_addr_i),
      .reg_wr_data_i (reg_wr_data_i),
      .reg_rd_req_i  (reg_rd_req_i),
      .reg_rd_addr_i (reg_rd_addr_i),
      .reg_rd_resp_o (mdio_rd_resp),
      .reg_rd_data_o (mdio_rd_data),
      .mdc_o         (mdc_o),
      .mdio_o        (mdio_o),
      .mdio_oe_o     (mdio_oe_o),
      .mdio_i        (mdio_i)
   );

endmodule

//--- source/sfpp_io_pkg.sv
// SFP+ port management definitions
// Register map, word types and MDIO frame timing shared by the core
package sfpp_io_pkg;

   // ------------------------------
   // Word types
   // ------------------------------
   typedef logic [31:0] reg_addr_t;     // Register port byte address
   typedef logic [31:0] reg_data_t;
   // MAC status bits 8..0: remote fault, local fault, pause rx,
   // rx FIFO underflow/overflow, tx FIFO underflow/overflow, fragment, CRC
   typedef logic [31:0] mac_status_t;
   typedef logic [15:0] phy_status_t;   // PHY core status
   typedef logic [15:0] mdio_data_t;
   typedef logic [4:0]  mdio_addr_t;    // PHY or register address

   // ------------------------------
   // Register map
   // ------------------------------
   localparam reg_addr_t REG_MAC_CTRL_STATUS = 32'h00; // Wr ctrl, rd status
   localparam reg_addr_t REG_PHY_CTRL_STATUS = 32'h04;
   localparam reg_addr_t REG_MDIO_CMD        = 32'h10; // Write only
   localparam reg_addr_t REG_MDIO_STATUS     = 32'h14; // {busy, rd data}

   localparam reg_data_t MAC_CTRL_RESET = 32'h0000_0001; // Tx enabled

   localparam int SYNC_STAGES = 2;  // Status synchronizer depth

   // MDIO timing
   localparam int MDC_HALF_PERIOD = 4; // bus_clk cycles per MDC half
   localparam int MDC_CNT_W       = $clog2(MDC_HALF_PERIOD);

   // Clause-22 frame layout, 64 MDC periods total
   localparam int MDIO_PREAMBLE_BITS = 32;
   localparam int MDIO_HEADER_BITS   = 14; // Start, opcode, PHY, register
   localparam int MDIO_TA_BITS       = 2;
   localparam int MDIO_DATA_BITS     = 16;

   typedef enum logic [2:0] {
      IDLE,
      PREAMBLE,
      HEADER,
      TURNAROUND,
      DATA,
      FINISH
   } mdio_state_t;

endpackage

//--- source/sfpp_reg_ctrl.sv
`timescale 1ns/1ns
// SFP+ register block
// MAC/PHY control words, status readback and read response merge
module sfpp_reg_ctrl
   import sfpp_io_pkg::*;
(
   input  logic        bus_clk,
   input  logic        bus_rst,
   // Register port
   input  logic        reg_wr_req_i,
   input  reg_addr_t   reg_wr_addr_i,
   input  reg_data_t   reg_wr_data_i,
   input  logic        reg_rd_req_i,
   input  reg_addr_t   reg_rd_addr_i,
   // Synced status
   input  mac_status_t mac_status_i,
   input  phy_status_t phy_status_i,
   // MDIO master read path
   input  logic        mdio_rd_resp_i,
   input  reg_data_t   mdio_rd_data_i,
   output logic        reg_rd_resp_o,
   output reg_data_t   reg_rd_data_o,
   // Control outputs
   output logic        tx_enable_o,
   output logic        phy_reset_o,
   output logic        sfpp_tx_disable_o
);

   reg_data_t mac_ctrl_q;
   reg_data_t phy_ctrl_q;
   reg_data_t readback_q;     // Status captured at read strobe
   logic      local_resp_q;
   logic      local_rd_hit;

   // ------------------------------
   // Control words
   // ------------------------------
   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         mac_ctrl_q <= MAC_CTRL_RESET;
         phy_ctrl_q <= '0;
      end else if (reg_wr_req_i) begin
         case (reg_wr_addr_i)
            REG_MAC_CTRL_STATUS: mac_ctrl_q <= reg_wr_data_i;
            REG_PHY_CTRL_STATUS: phy_ctrl_q <= reg_wr_data_i;
            default: ;                     // Other blocks or unmapped
         endcase
      end
   end

   assign tx_enable_o       = mac_ctrl_q[0];
   assign phy_reset_o       = phy_ctrl_q[0];
   assign sfpp_tx_disable_o = phy_ctrl_q[1];

   // ------------------------------
   // Status readback
   // ------------------------------
   assign local_rd_hit = reg_rd_req_i &&
                         (reg_rd_addr_i == REG_MAC_CTRL_STATUS ||
                          reg_rd_addr_i == REG_PHY_CTRL_STATUS);

   always_ff @(posedge bus_clk) begin
      if (bus_rst)
         local_resp_q <= 1'b0;
      else
         local_resp_q <= local_rd_hit;   // One cycle after strobe
   end

   always_ff @(posedge bus_clk) begin
      if (local_rd_hit) begin
         if (reg_rd_addr_i == REG_MAC_CTRL_STATUS)
            readback_q <= mac_status_i;
         else
            readback_q <= {16'h0000, phy_status_i};  // Zero-extended
      end
   end

   // Merge with MDIO path, MDIO data wins on its strobe
   assign reg_rd_resp_o = local_resp_q | mdio_rd_resp_i;
   assign reg_rd_data_o = mdio_rd_resp_i ? mdio_rd_data_i : readback_q;

   // Responses are single pulses given the one-read-in-flight rule
   assert property (@(posedge bus_clk) disable iff (bus_rst)
      reg_rd_resp_o |=> !reg_rd_resp_o);

   // Address decode keeps the two responders apart
   assert property (@(posedge bus_clk) disable iff (bus_rst)
      !(local_resp_q && mdio_rd_resp_i));

endmodule

//--- source/status_sync.sv
`timescale 1ns/1ns
// Status synchronizer
// Brings the asynchronous MAC and PHY status words into bus_clk
module status_sync
   import sfpp_io_pkg::*;
(
   input  logic        bus_clk,
   input  logic        bus_rst,
   input  mac_status_t mac_status_i,  // Asynchronous
   input  phy_status_t phy_status_i,  // Asynchronous
   output mac_status_t mac_status_o,
   output phy_status_t phy_status_o
);

   mac_status_t mac_sync_q [SYNC_STAGES];
   phy_status_t phy_sync_q [SYNC_STAGES];

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            mac_sync_q[i] <= '0;
            phy_sync_q[i] <= '0;
         end
      end else begin
         mac_sync_q[0] <= mac_status_i;  // Metastable stage
         phy_sync_q[0] <= phy_status_i;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            mac_sync_q[i] <= mac_sync_q[i-1];
            phy_sync_q[i] <= phy_sync_q[i-1];
         end
      end
   end

   assign mac_status_o = mac_sync_q[SYNC_STAGES-1];
   assign phy_status_o = phy_sync_q[SYNC_STAGES-1];

endmodule

//--- tb/mdio_phy_model.sv
`timescale 1ns/1ns
// Behavioral Clause-22 PHY
// Decodes MDIO frames on MDC and answers reads for one PHY address
module mdio_phy_model
   import sfpp_io_pkg::*;
(
   input  logic mdc_i,
   input  logic mdio_i,      // Master data out
   input  logic mdio_oe_i,   // Master owns the line
   output logic mdio_o,      // Line as the master sees it
   output logic error_o      // Protocol violation seen
);

   localparam mdio_addr_t MY_PHY_ADDR = 5'd5;

   mdio_data_t  regs [32];
   logic [31:0] frame_bits;  // Start bit onward, newest in bit 0
   int          ones_cnt;
   int          nbits;       // Bits taken since the first start bit
   logic        in_frame;
   logic        is_read;
   logic        to_us;
   mdio_addr_t  reg_addr;
   mdio_data_t  rd_word;
   logic        drive_q;
   logic        drive_bit_q;
   logic        line_bit;

   initial begin
      for (int i = 0; i < 32; i++)
         regs[i] = '0;
      ones_cnt = 0;
      nbits    = 0;
      in_frame = 1'b0;
      is_read  = 1'b0;
      to_us    = 1'b0;
      drive_q  = 1'b0;
      error_o  = 1'b0;
   end

   assign mdio_o   = drive_q ? drive_bit_q : 1'b1;   // Pull-up when nobody drives
   assign line_bit = mdio_oe_i ? mdio_i : mdio_o;

   // ------------------------------
   // Frame decode on MDC rise
   // ------------------------------
   always @(posedge mdc_i) begin
      if (!in_frame) begin
         if (line_bit) begin
            ones_cnt++;                               // Preamble
         end else if (ones_cnt < MDIO_PREAMBLE_BITS) begin
            $display("MDIO PHY model saw a preamble of %0d ones, too short", ones_cnt);
            error_o = 1'b1;
         end else begin
            in_frame   = 1'b1;                        // First start bit
            to_us      = 1'b0;
            frame_bits = '0;
            nbits      = 1;
         end
      end else begin
         frame_bits = {frame_bits[30:0], line_bit};
         nbits++;
         if (nbits == 2 && !line_bit) begin
            $display("MDIO PHY model saw start bits other than 01");
            error_o = 1'b1;
         end
         if (nbits == 14) begin                       // Header complete
            if (frame_bits[11:10] != 2'b10 && frame_bits[11:10] != 2'b01) begin
               $display("MDIO PHY model saw unknown opcode %b", frame_bits[11:10]);
               error_o = 1'b1;
            end
            is_read  = (frame_bits[11:10] == 2'b10);
            to_us    = (frame_bits[9:5] == MY_PHY_ADDR);
            reg_addr = frame_bits[4:0];
            rd_word  = regs[frame_bits[4:0]];
         end
         if (nbits == 16 && !is_read && frame_bits[1:0] != 2'b10) begin
            $display("MDIO PHY model saw a write turnaround other than 10");
            error_o = 1'b1;
         end
         if (nbits == 32) begin
            if (!is_read && to_us)
               regs[reg_addr] = frame_bits[15:0];
            in_frame = 1'b0;
            ones_cnt = 0;
         end
      end
   end

   // Read data leaves after MDC falls, second TA bit driven low
   always @(negedge mdc_i) begin
      if (in_frame && is_read && to_us && nbits >= 15) begin
         drive_q <= 1'b1;
         if (nbits == 15)
            drive_bit_q <= 1'b0;
         else
            drive_bit_q <= rd_word[31 - nbits];   // MSB first
      end else begin
         drive_q <= 1'b0;
      end
   end

endmodule

//--- tb/sfpp_io_tb.sv
`timescale 1ns/1ns
// Testbench for the SFP+ port management core
// Random register traffic and MDIO frames checked against a local model
module sfpp_io_tb
   import sfpp_io_pkg::*;
();

   localparam int N_CTRL_WRITES  = 50;
   localparam int N_STATUS_READS = 50;
   localparam int N_MDIO_PAIRS   = 20;
   localparam int FRAME_CYCLES   = 520;  // 64 MDC periods plus start and finish
   localparam int MDIO_FRAMES    = 2 * N_MDIO_PAIRS + 3;  // Pairs, foreign, busy
   localparam int TIMEOUT_CYCLES = MDIO_FRAMES * FRAME_CYCLES + 2000;
   localparam mdio_addr_t PHY_ADDR = 5'd5;

   logic        bus_clk;
   logic        bus_rst;
   logic        reg_wr_req;
   reg_addr_t   reg_wr_addr;
   reg_data_t   reg_wr_data;
   logic        reg_rd_req;
   reg_addr_t   reg_rd_addr;
   logic        reg_rd_resp;
   reg_data_t   reg_rd_data;
   mac_status_t mac_status;
   phy_status_t phy_status;
   logic        tx_enable;
   logic        phy_reset;
   logic        sfpp_tx_disable;
   logic        mdc;
   logic        mdio_out;
   logic        mdio_oe;
   logic        mdio_in;
   logic        phy_error;

   // Reference model
   reg_data_t   mac_ctrl_m;
   reg_data_t   phy_ctrl_m;
   mac_status_t mac_status_m;
   phy_status_t phy_status_m;
   mdio_data_t  phy_regs_m [32];
   integer      seed;
   int          cycle_count = 0;

   sfpp_io_core dut0 (
      .bus_clk           (bus_clk),
      .bus_rst           (bus_rst),
      .reg_wr_req_i      (reg_wr_req),
      .reg_wr_addr_i     (reg_wr_addr),
      .reg_wr_data_i     (reg_wr_data),
      .reg_rd_req_i      (reg_rd_req),
      .reg_rd_addr_i     (reg_rd_addr),
      .reg_rd_resp_o     (reg_rd_resp),
      .reg_rd_data_o     (reg_rd_data),
      .mac_status_i      (mac_status),
      .phy_status_i      (phy_status),
      .tx_enable_o       (tx_enable),
      .phy_reset_o       (phy_reset),
      .sfpp_tx_disable_o (sfpp_tx_disable),
      .mdc_o             (mdc),
      .mdio_o            (mdio_out),
      .mdio_oe_o         (mdio_oe),
      .mdio_i            (mdio_in)
   );

   mdio_phy_model phy0 (
      .mdc_i     (mdc),
      .mdio_i    (mdio_out),
      .mdio_oe_i (mdio_oe),
      .mdio_o    (mdio_in),
      .error_o   (phy_error)
   );

   initial bus_clk = 1'b0;
   always #5 bus_clk = ~bus_clk;   // 10 ns period

   always @(posedge bus_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         fail_run($sformatf("Timeout, run still going after %0d cycles", cycle_count));
   end

   always @(posedge phy_error)
      fail_run("MDIO PHY model reported a protocol violation");

   // ------------------------------
   // Checks
   // ------------------------------
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_data(input string test, input reg_data_t exp, input reg_data_t act);
      if (act !== exp)
         fail_run($sformatf("Fail %s expected %h actual %h", test, exp, act));
   endtask

   task automatic check_bit(input string test, input logic exp, input logic act);
      if (act !== exp)
         fail_run($sformatf("Fail %s expected %b actual %b", test, exp, act));
   endtask

   task automatic check_mdio(input string test, input mdio_data_t exp, input mdio_data_t act);
      if (act !== exp)
         fail_run($sformatf("Fail %s expected %h actual %h", test, exp, act));
   endtask

   // ------------------------------
   // Register port access
   // ------------------------------
   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      @(posedge bus_clk);
      reg_wr_req  <= 1'b1;
      reg_wr_addr <= addr;
      reg_wr_data <= data;
      @(posedge bus_clk);                       // DUT takes the strobe here
      reg_wr_req  <= 1'b0;
   endtask

   // Response sampled mid-cycle, one cycle after the strobe
   task automatic reg_read(input reg_addr_t addr, output logic got, output reg_data_t data);
      @(posedge bus_clk);
      reg_rd_req  <= 1'b1;
      reg_rd_addr <= addr;
      @(negedge bus_clk);
      check_bit("no response in strobe cycle", 1'b0, reg_rd_resp);
      @(posedge bus_clk);
      reg_rd_req  <= 1'b0;
      @(negedge bus_clk);
      got  = reg_rd_resp;
      data = reg_rd_data;
   endtask

   function automatic reg_addr_t unmapped_addr();
      return 32'h18 + 4 * ({$random(seed)} % 48);   // Clear of all four registers
   endfunction

   // ------------------------------
   // MDIO access
   // ------------------------------
   task automatic mdio_cmd(input logic rnw, input mdio_addr_t phy, input mdio_addr_t regad,
                           input mdio_data_t wdata);
      reg_write(REG_MDIO_CMD, {5'b00000, rnw, phy, regad, wdata});
   endtask

   task automatic wait_mdio_idle(output reg_data_t status);
      logic got;
      do begin
         reg_read(REG_MDIO_STATUS, got, status);
         check_bit("mdio status response", 1'b1, got);
      end while (status[16]);                   // Busy flag
   endtask

   task automatic mdio_write(input mdio_addr_t phy, input mdio_addr_t regad,
                             input mdio_data_t wdata);
      reg_data_t status;
      mdio_cmd(1'b0, phy, regad, wdata);
      wait_mdio_idle(status);
   endtask

   task automatic mdio_read(input mdio_addr_t phy, input mdio_addr_t regad,
                            output mdio_data_t rdata);
      reg_data_t status;
      mdio_cmd(1'b1, phy, regad, '0);
      wait_mdio_idle(status);
      rdata = status[15:0];
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      logic       got;
      reg_data_t  rdata;
      reg_addr_t  addr;
      reg_data_t  wdata;
      mdio_addr_t pa;
      mdio_addr_t ra;
      mdio_addr_t rb;
      mdio_data_t mdata;
      int         sel;

      seed        = 32'h54908377;
      bus_rst     = 1'b1;
      reg_wr_req  = 1'b0;
      reg_wr_addr = '0;
      reg_wr_data = '0;
      reg_rd_req  = 1'b0;
      reg_rd_addr = '0;
      mac_status  = '0;
      phy_status  = '0;
      mac_ctrl_m  = MAC_CTRL_RESET;
      phy_ctrl_m  = '0;
      for (int i = 0; i < 32; i++)
         phy_regs_m[i] = '0;
      repeat (8) @(posedge bus_clk);
      bus_rst <= 1'b0;

      // Reset state
      @(negedge bus_clk);
      check_bit("reset tx_enable", 1'b1, tx_enable);
      check_bit("reset phy_reset", 1'b0, phy_reset);
      check_bit("reset sfpp_tx_disable", 1'b0, sfpp_tx_disable);
      repeat (20) begin
         @(negedge bus_clk);
         check_bit("reset mdc", 1'b0, mdc);
         check_bit("reset mdio_oe", 1'b0, mdio_oe);
         check_bit("reset rd_resp", 1'b0, reg_rd_resp);
      end
      reg_read(REG_MDIO_STATUS, got, rdata);
      check_bit("reset mdio status response", 1'b1, got);
      check_bit("reset mdio busy", 1'b0, rdata[16]);

      // Control writes, some to unmapped space
      for (int n = 0; n < N_CTRL_WRITES; n++) begin
         sel   = {$random(seed)} % 3;
         addr  = (sel == 0) ? REG_MAC_CTRL_STATUS :
                 (sel == 1) ? REG_PHY_CTRL_STATUS : unmapped_addr();
         wdata = $random(seed);
         reg_write(addr, wdata);
         if (addr == REG_MAC_CTRL_STATUS)
            mac_ctrl_m = wdata;
         else if (addr == REG_PHY_CTRL_STATUS)
            phy_ctrl_m = wdata;
         @(negedge bus_clk);
         check_bit("ctrl write tx_enable", mac_ctrl_m[0], tx_enable);
         check_bit("ctrl write phy_reset", phy_ctrl_m[0], phy_reset);
         check_bit("ctrl write sfpp_tx_disable", phy_ctrl_m[1], sfpp_tx_disable);
      end

      // Status readback through the synchronizer
      for (int n = 0; n < N_STATUS_READS; n++) begin
         @(posedge bus_clk);
         mac_status_m = $random(seed);
         phy_status_m = $random(seed);
         mac_status  <= mac_status_m;
         phy_status  <= phy_status_m;
         repeat (4) @(posedge bus_clk);         // Held past both sync stages
         sel = {$random(seed)} % 4;
         if (sel == 3) begin
            reg_read(unmapped_addr(), got, rdata);
            check_bit("unmapped read response", 1'b0, got);
            repeat (2) begin
               @(negedge bus_clk);
               check_bit("unmapped read late response", 1'b0, reg_rd_resp);
            end
         end else begin
            addr = (sel == 1) ? REG_PHY_CTRL_STATUS : REG_MAC_CTRL_STATUS;
            reg_read(addr, got, rdata);
            check_bit("status read response", 1'b1, got);
            check_data("status read data",
                       (sel == 1) ? {16'h0000, phy_status_m} : mac_status_m, rdata);
         end
      end

      // MDIO write then read back
      for (int n = 0; n < N_MDIO_PAIRS; n++) begin
         ra    = $random(seed);
         mdata = $random(seed);
         mdio_write(PHY_ADDR, ra, mdata);
         phy_regs_m[ra] = mdata;
         mdio_read(PHY_ADDR, ra, mdata);
         check_mdio("mdio write then read", phy_regs_m[ra], mdata);
      end

      // Nobody answers a foreign PHY address
      pa = $random(seed);
      if (pa == PHY_ADDR)
         pa = pa + 1'b1;
      rb = $random(seed);
      mdio_read(pa, rb, mdata);
      check_mdio("foreign phy read", 16'hFFFF, mdata);

      // Second command while busy is dropped
      ra    = $random(seed);
      rb    = ra + 1'b1;
      mdata = $random(seed);
      mdio_cmd(1'b0, PHY_ADDR, ra, mdata);
      phy_regs_m[ra] = mdata;
      reg_read(REG_MDIO_STATUS, got, rdata);
      check_bit("busy after command", 1'b1, rdata[16]);
      mdio_cmd(1'b0, PHY_ADDR, rb, ~phy_regs_m[rb]);
      wait_mdio_idle(rdata);
      mdio_read(PHY_ADDR, rb, mdata);
      check_mdio("command while busy", phy_regs_m[rb], mdata);

      $display("No errors");
      $finish;
   end

endmodule
